//--- dv/stringStimulus.txt
# Columns: A B index length expected, all hex, byte 0 is the top byte
# Expected byte p is B[p-index] for index <= p < index+length, else A[p]
41424344 61626364 0 0 41424344
41424344 61626364 0 4 61626364
41424344 61626364 1 2 41616244
41424344 61626364 2 5 41426162
41424344 61626364 4 3 41424344
41424344 61626364 3 7 41424361
41424344 61626364 7 7 41424344
41424344 61626364 0 1 61424344
41424344 61626364 2 0 41424344
41424344 61626364 1 7 41616263
DEADBEEF 01234567 0 2 0123BEEF
DEADBEEF 01234567 3 1 DEADBE01
DEADBEEF 01234567 1 3 DE012345
DEADBEEF 01234567 2 2 DEAD0123
00000000 FFFFFFFF 1 1 00FF0000
00000000 FFFFFFFF 0 7 FFFFFFFF
00000000 FFFFFFFF 3 3 000000FF
12345678 9ABCDEF0 2 1 12349A78
12345678 9ABCDEF0 0 3 9ABCDE78
12345678 9ABCDEF0 5 2 12345678
12345678 9ABCDEF0 1 4 129ABCDE
12345678 9ABCDEF0 6 0 12345678

//--- src.f
design/stringPkg.sv
design/stringAvalonSlave.sv
design/jobQueue.sv
design/spliceEngine.sv
design/stringAccelTop.sv
dv/stringAccel_asserts.sv
dv/stringAccelTb.sv

//--- runSim.sh
#!/bin/sh
# Build and run the string accelerator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module stringAccelTb -f src.f -o simStringAccel

out=$(./obj_dir/simStringAccel)
echo "$out"

if echo "$out" | grep -q "Simulation finished: PASS"; then
   exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- dv/stringAccelTb.sv
// Testbench for the string splice accelerator
// Clock and reset, Avalon read and write tasks, stimulus file reader
// Register readback, single splices, exact latency, queued jobs, overflow
// Closing report with error and timeout counts
module stringAccelTb
   import stringPkg::*;
();

   localparam int queueDepth = 4;
   localparam int clkPeriod  = 100;
   localparam int driveDelay = 10;  // Inputs change after the rising edge
   localparam int pollLimit  = 100; // Status reads per wait
   localparam int maxJobs    = 32;

   logic       clk;
   logic       reset;
   logic [1:0] address;
   logic       chipselect;
   logic       read;
   logic       write;
   wordT       writedata;
   wordT       readdata;

   int         errors;
   int         timeouts;
   int         numJobs;
   logic [7:0] expDone;        // Finished jobs so far
   wordT       jobA   [maxJobs];
   wordT       jobB   [maxJobs];
   bytePosT    jobIdx [maxJobs];
   bytePosT    jobLen [maxJobs];
   wordT       jobExp [maxJobs];

   stringAccelTop #(.queueDepth(queueDepth)) i_dut (
      .clk, .reset, .address, .chipselect, .read, .write, .writedata, .readdata
   );

   initial begin
      clk = 1'b0;
      forever #(clkPeriod / 2) clk = ~clk;
   end

   // One write cycle, bus idle again on return
   task automatic busWrite(input logic [1:0] addr, input wordT data);
      chipselect = 1'b1;
      write      = 1'b1;
      read       = 1'b0;
      address    = addr;
      writedata  = data;
      @(posedge clk);
      #driveDelay;
      chipselect = 1'b0;
      write      = 1'b0;
   endtask

   // Read issued now, data taken in the following cycle
   task automatic busRead(input logic [1:0] addr, output wordT data);
      chipselect = 1'b1;
      read       = 1'b1;
      write      = 1'b0;
      address    = addr;
      @(posedge clk);
      #driveDelay;
      chipselect = 1'b0;
      read       = 1'b0;
      data       = readdata; // Registered at the edge just passed
   endtask

   task automatic idleCycles(input int n);
      repeat (n) begin
         @(posedge clk);
         #driveDelay;
      end
   endtask

   // Control word with the go bit set
   function automatic wordT goWord(input bytePosT idx, input bytePosT len);
      wordT w;
      w                   = '0;
      w[CTRL_GO]          = 1'b1;
      w[CTRL_INDEX +: 3]  = idx;
      w[CTRL_LENGTH +: 3] = len;
      return w;
   endfunction

   task automatic checkValue(input wordT got, input wordT exp, input string what);
      assert (got === exp) else begin
         errors++;
         $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   // Poll status until the done count reaches expDone
   task automatic waitForCount(input string what);
      wordT stat;
      int   polls;
      polls = 0;
      busRead(ADDR_CTRL, stat);
      while (stat[STAT_DONE +: 8] != expDone && polls < pollLimit) begin
         busRead(ADDR_CTRL, stat);
         polls++;
      end
      if (stat[STAT_DONE +: 8] != expDone) begin
         timeouts++;
         $display("Timeout waiting for %s: done count stuck at %0d, expected %0d",
                  what, stat[STAT_DONE +: 8], expDone);
      end
   endtask

   task automatic loadStimulus();
      int    fd;
      int    fields;
      string line;
      wordT  a;
      wordT  b;
      wordT  idx;
      wordT  len;
      wordT  expWord;
      numJobs = 0;
      fd = $fopen("dv/stringStimulus.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the stimulus file dv/stringStimulus.txt");
         errors++;
         return;
      end
      while (!$feof(fd) && numJobs < maxJobs) begin
         if ($fgets(line, fd) == 0)
            break;
         if (line.len() < 2 || line.getc(0) == "#")
            continue; // Column notes or blank line
         fields = $sscanf(line, "%h %h %h %h %h", a, b, idx, len, expWord);
         if (fields == 5) begin
            jobA[numJobs]   = a;
            jobB[numJobs]   = b;
            jobIdx[numJobs] = idx[2:0];
            jobLen[numJobs] = len[2:0];
            jobExp[numJobs] = expWord;
            numJobs++;
         end
      end
      $fclose(fd);
   endtask

   // A, B and go write, last one sampled at the edge before return
   task automatic runJob(input int k);
      busWrite(ADDR_A, jobA[k]);
      busWrite(ADDR_B, jobB[k]);
      busWrite(ADDR_CTRL, goWord(jobIdx[k], jobLen[k]));
   endtask

   task automatic checkRegisters();
      wordT got;
      checkValue(readdata, '0, "readdata after reset");
      busRead(ADDR_CTRL, got);
      checkValue(got, '0, "status after reset");
      busWrite(ADDR_A, 32'hCAFE_F00D);
      busWrite(ADDR_B, 32'h0BAD_BEEF);
      busRead(ADDR_A, got);
      checkValue(got, 32'hCAFE_F00D, "A readback");
      busRead(ADDR_B, got);
      checkValue(got, 32'h0BAD_BEEF, "B readback");
   endtask

   task automatic singleJobs();
      wordT got;
      for (int k = 0; k < numJobs; k++) begin
         runJob(k);
         expDone++;
         waitForCount($sformatf("job %0d", k));
         busRead(ADDR_RESULT, got);
         checkValue(got, jobExp[k], $sformatf("result of job %0d", k));
      end
   endtask

   // Go at edge n, resultValid in cycle n+6, new count visible at edge n+7
   task automatic checkLatency();
      wordT early;
      wordT late;
      wordT got;
      runJob(2);
      idleCycles(5);
      busRead(ADDR_CTRL, early); // Sampled at edge n+6
      busRead(ADDR_CTRL, late);  // Sampled at edge n+7
      checkValue(wordT'(early[STAT_DONE +: 8]), wordT'(expDone), "done count 6 cycles after go");
      checkValue(wordT'(early[STAT_BUSY]), 32'd1, "busy in FINISH cycle");
      expDone++;
      checkValue(wordT'(late[STAT_DONE +: 8]), wordT'(expDone), "done count 7 cycles after go");
      checkValue(wordT'(late[STAT_BUSY]), 32'd0, "busy after result");
      busRead(ADDR_RESULT, got);
      checkValue(got, jobExp[2], "result of latency job");
   endtask

   // Jobs 5 to 9 share A and B
   task automatic queuedJobs();
      wordT got;
      int   gap;
      busWrite(ADDR_A, jobA[5]);
      busWrite(ADDR_B, jobB[5]);
      for (int k = 5; k <= 5 + queueDepth; k++) begin
         busWrite(ADDR_CTRL, goWord(jobIdx[k], jobLen[k]));
         gap = $urandom % 3; // 0 to 2 idle cycles
         idleCycles(gap);
      end
      // First job goes straight to the idle engine and the rest wait in the queue
      expDone = expDone + 8'(queueDepth + 1);
      waitForCount("queued jobs");
      busRead(ADDR_RESULT, got);
      checkValue(got, jobExp[5 + queueDepth], "result of last queued job");
      busRead(ADDR_CTRL, got);
      checkValue(wordT'(got[STAT_OVERFLOW]), 32'd0, "overflow after queued jobs");
   endtask

   // Go writes in consecutive cycles, jobs cycle through lines 10 to 13
   task automatic overflowJobs();
      wordT got;
      busWrite(ADDR_A, jobA[10]);
      busWrite(ADDR_B, jobB[10]);
      for (int j = 0; j < queueDepth + 2; j++)
         busWrite(ADDR_CTRL, goWord(jobIdx[10 + j % 4], jobLen[10 + j % 4]));
      busRead(ADDR_CTRL, got);
      checkValue(wordT'(got[STAT_OVERFLOW]), 32'd1, "overflow after burst");
      // Engine holds one job and the queue the next queueDepth, so the last write is dropped
      expDone = expDone + 8'(queueDepth + 1);
      waitForCount("overflow burst");
      idleCycles(12); // Two job lengths for any late result
      busRead(ADDR_CTRL, got);
      checkValue(wordT'(got[STAT_DONE +: 8]), wordT'(expDone), "done count after burst");
      checkValue(wordT'(got[STAT_OVERFLOW]), 32'd1, "overflow still set");
      busRead(ADDR_RESULT, got);
      checkValue(got, jobExp[10 + queueDepth % 4], "result of last accepted job");
   endtask

   initial begin
      errors     = 0;
      timeouts   = 0;
      expDone    = '0;
      reset      = 1'b1;
      chipselect = 1'b0;
      read       = 1'b0;
      write      = 1'b0;
      address    = '0;
      writedata  = '0;
      void'($urandom(32'h8627)); // Seed once
      loadStimulus();
      repeat (8) @(posedge clk);
      #driveDelay;
      reset = 1'b0;

      if (numJobs < 14) begin
         $display("The stimulus file holds too few jobs: %0d", numJobs);
         errors++;
      end else begin
         checkRegisters();
         singleJobs();
         checkLatency();
         queuedJobs();
         overflowJobs();
      end

      $display("Checks done with %0d errors and %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

//--- dv/stringAccel_asserts.sv
// Bound assertions for the string accelerator
// Queue level model with push on full, pop on empty and flag checks
// Optional fixed latency from a start pulse to a done pulse
module stringAccelAsserts #(
   parameter int depth   = 0, // 0 turns the queue checks off
   parameter int latency = 0  // 0 turns the latency check off
) (
   input logic clk,
   input logic reset,
   input logic pushReq,
   input logic popReq,
   input logic full,
   input logic empty,
   input logic startPulse,
   input logic donePulse
);

   if (depth > 0) begin : queueChecks
      int level; // Jobs held according to the port requests

      always_ff @(posedge clk or posedge reset) begin
         if (reset)
            level <= 0;
         else
            level <= level + (pushReq ? 1 : 0) - (popReq ? 1 : 0);
      end

      pushNotFull: assert property (@(posedge clk) disable iff (reset)
         pushReq |-> level < depth)
         else $error("Push into a queue that already holds every job it can");
      popNotEmpty: assert property (@(posedge clk) disable iff (reset)
         popReq |-> level > 0)
         else $error("Pop from an empty queue");
      flagsMatchLevel: assert property (@(posedge clk) disable iff (reset)
         (full == (level == depth)) && (empty == (level == 0)))
         else $error("Full or empty flag disagrees with the number of queued jobs");
   end

   if (latency > 0) begin : latencyChecks
      // Pop cycle, 4 SPLICE cycles, then FINISH
      doneAfterStart: assert property (@(posedge clk) disable iff (reset)
         $past(startPulse, latency) |-> donePulse)
         else $error("No result at the expected cycle after pop");
      startBeforeDone: assert property (@(posedge clk) disable iff (reset)
         donePulse |-> $past(startPulse, latency))
         else $error("Result without a pop at the expected cycle before");
   end

endmodule

bind jobQueue stringAccelAsserts #(.depth(queueDepth)) i_queueAsserts (
   .clk(clk), .reset(reset), .pushReq(pushValid), .popReq(pop),
   .full(full), .empty(empty), .startPulse(1'b0), .donePulse(1'b0)
);

bind spliceEngine stringAccelAsserts #(.latency(5)) i_engineAsserts (
   .clk(clk), .reset(reset), .pushReq(1'b0), .popReq(1'b0),
   .full(1'b0), .empty(1'b0), .startPulse(pop), .donePulse(resultValid)
);

//--- design/stringAccelTop.sv
// String accelerator top level
// Avalon slave feeding the job FIFO, splice engine draining it
module stringAccelTop
   import stringPkg::*;
#(
   parameter int queueDepth = 4 // Jobs waiting, power of two
) (
   input  logic       clk,
   input  logic       reset,
   input  logic [1:0] address,
   input  logic       chipselect,
   input  logic       read,
   input  logic       write,
   input  wordT       writedata,
   output wordT       readdata
);

   logic pushValid;
   jobT  pushJob;
   logic full;
   logic empty;
   jobT  headJob;
   logic pop;
   logic resultValid;
   wordT result;
   logic busy;

   stringAvalonSlave i_slave (
      .clk, .reset, .address, .chipselect, .read, .write, .writedata, .readdata,
      .pushValid, .pushJob, .full,
      .resultValid, .result, .busy
   );

   jobQueue #(.queueDepth(queueDepth)) i_queue (
      .clk, .reset,
      .pushValid, .pushJob,
      .pop, .headJob, .full, .empty
   );

   spliceEngine i_engine (
      .clk, .reset,
      .empty, .headJob, .pop,
      .resultValid, .result, .busy
   );

endmodule

//--- design/spliceEngine.sv
// Splice engine FSM
// Pops one job, builds the result a byte per cycle
// Presents the finished word with a one-cycle resultValid
module spliceEngine
   import stringPkg::*;
(
   input  logic clk,
   input  logic reset,
   input  logic empty,
   input  jobT  headJob,
   output logic pop,
   output logic resultValid,
   output wordT result,
   output logic busy
);

   engineStateT state;
   jobT         curJob;   // Job being worked on
   bytePosT     pos;      // Result byte, 0 to 3
   wordT        work;
   wordT        jobA;
   wordT        jobB;
   bytePosT     jobIndex;
   bytePosT     jobLength;
   logic [3:0]  spanEnd;  // index + length, up to 14
   logic        inSpan;
   logic [1:0]  srcPos;   // Byte of B to take
   logic [7:0]  newByte;

   // Unpack current job
   assign jobA      = curJob[69:38];
   assign jobB      = curJob[37:6];
   assign jobIndex  = curJob[5:3];
   assign jobLength = curJob[2:0];

   // Splice rule, byte 0 sits in the top byte
   assign spanEnd = {1'b0, jobIndex} + {1'b0, jobLength};
   assign inSpan  = (pos >= jobIndex) && ({1'b0, pos} < spanEnd);
   assign srcPos  = 2'(pos - jobIndex); // Valid only when inSpan
   assign newByte = inSpan ? jobB[8*(3-srcPos) +: 8] : jobA[8*(3-pos[1:0]) +: 8];

   assign pop         = (state == IDLE) && !empty; // Head captured same cycle
   assign resultValid = (state == FINISH);
   assign result      = work;
   assign busy        = (state != IDLE);

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state <= IDLE;
         pos   <= '0;
      end else begin
         case (state)
            IDLE: begin
               pos <= '0;
               if (!empty)
                  state <= SPLICE;
            end
            SPLICE: begin
               pos <= pos + 3'd1;
               if (pos == 3'd3)
                  state <= FINISH; // Last byte written this cycle
            end
            default: state <= IDLE; // FINISH lasts one cycle
         endcase
      end
   end

   // Job capture and working word
   always_ff @(posedge clk) begin
      if (pop)
         curJob <= headJob;
      if (state == SPLICE)
         work[8*(3-pos[1:0]) +: 8] <= newByte;
   end

endmodule

//--- design/jobQueue.sv
// Job FIFO between bus slave and splice engine
// Circular buffer, read/write pointers and occupancy count
// Oldest entry always shown on headJob
module jobQueue
   import stringPkg::*;
#(
   parameter int queueDepth = 4 // Power of two
) (
   input  logic clk,
   input  logic reset,
   input  logic pushValid,
   input  jobT  pushJob,
   input  logic pop,
   output jobT  headJob,
   output logic full,
   output logic empty
);

   localparam int PTR_W = $clog2(queueDepth);

   jobT              mem [queueDepth];
   logic [PTR_W-1:0] wrPtr;
   logic [PTR_W-1:0] rdPtr;
   logic [PTR_W:0]   count; // One bit more than the pointers
   logic             doPush;
   logic             doPop;

   assign full  = (count == (PTR_W+1)'(queueDepth));
   assign empty = (count == '0);

   assign doPush = pushValid && !full;
   assign doPop  = pop && !empty;

   assign headJob = mem[rdPtr];

   // Storage, no reset on payload
   always_ff @(posedge clk) begin
      if (doPush)
         mem[wrPtr] <= pushJob;
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end else begin
         if (doPush)
            wrPtr <= wrPtr + 1'b1; // Wraps, depth is a power of two
         if (doPop)
            rdPtr <= rdPtr + 1'b1;
         // Push and pop together leave count alone
         if (doPush && !doPop)
            count <= count + 1'b1;
         else if (doPop && !doPush)
            count <= count - 1'b1;
      end
   end

endmodule

//--- design/stringAvalonSlave.sv
// Avalon-MM slave of the string accelerator
// A, B and last result registers, status word build
// Job packing on a go write, overflow flag and done counter
module stringAvalonSlave
   import stringPkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic [1:0] address,
   input  logic       chipselect,
   input  logic       read,
   input  logic       write,
   input  wordT       writedata,
   output wordT       readdata,
   output logic       pushValid,
   output jobT        pushJob,
   input  logic       full,
   input  logic       resultValid,
   input  wordT       result,
   input  logic       busy
);

   logic       wrEn;
   logic       rdEn;
   logic       goWrite;
   wordT       regA;
   wordT       regB;
   wordT       lastResult;
   wordT       status;
   logic       overflow;
   logic [7:0] doneCount;
   bytePosT    ctrlIndex;
   bytePosT    ctrlLength;

   assign wrEn = chipselect && write; // No wait states
   assign rdEn = chipselect && read;

   // Go bit of a control write starts a job
   assign goWrite    = wrEn && (address == ADDR_CTRL) && writedata[CTRL_GO];
   assign ctrlIndex  = writedata[CTRL_INDEX +: 3];
   assign ctrlLength = writedata[CTRL_LENGTH +: 3];

   // Push in the same cycle, dropped when queue full
   assign pushValid = goWrite && !full;
   assign pushJob   = {regA, regB, ctrlIndex, ctrlLength};

   // Status word
   always_comb begin
      status                  = '0;
      status[STAT_BUSY]       = busy;
      status[STAT_FULL]       = full;
      status[STAT_OVERFLOW]   = overflow;
      status[STAT_DONE +: 8]  = doneCount;
   end

   // Data registers, written by the bus or the engine
   always_ff @(posedge clk) begin
      if (wrEn && (address == ADDR_A))
         regA <= writedata;
      if (wrEn && (address == ADDR_B))
         regB <= writedata;
      if (resultValid)
         lastResult <= result; // Only the newest result kept
   end

   // Sticky overflow and finished job count
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         overflow  <= 1'b0;
         doneCount <= '0;
      end else begin
         if (goWrite && full)
            overflow <= 1'b1; // Cleared only by reset
         if (resultValid)
            doneCount <= doneCount + 8'd1; // Wraps at 256
      end
   end

   // Read data, fixed latency of one
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         readdata <= '0;
      end else if (rdEn) begin
         case (address)
            ADDR_A:    readdata <= regA;
            ADDR_B:    readdata <= regB;
            ADDR_CTRL: readdata <= status;
            default:   readdata <= lastResult; // ADDR_RESULT
         endcase
      end
   end

endmodule

//--- design/stringPkg.sv
// Shared types for the string splice accelerator
// Word, byte position, packed job and engine state types
// Avalon register map and control/status bit positions
package stringPkg;

   typedef logic [31:0] wordT;    // Bus and data word
   typedef logic [2:0]  bytePosT; // Start position or byte count
   typedef logic [69:0] jobT;     // {A, B, index, length}

   // Splice engine states
   typedef enum logic [1:0] {
      IDLE,
      SPLICE,
      FINISH
   } engineStateT;

   // Register map, word addresses
   localparam logic [1:0] ADDR_A      = 2'd0;
   localparam logic [1:0] ADDR_B      = 2'd1;
   localparam logic [1:0] ADDR_CTRL   = 2'd2; // Status on read
   localparam logic [1:0] ADDR_RESULT = 2'd3;

   // Control word fields (lsb positions)
   localparam int CTRL_GO     = 0;
   localparam int CTRL_INDEX  = 1; // 3 bits
   localparam int CTRL_LENGTH = 4; // 3 bits

   // Status word fields
   localparam int STAT_BUSY     = 0;
   localparam int STAT_FULL     = 1;
   localparam int STAT_OVERFLOW = 2;
   localparam int STAT_DONE     = 8; // 8-bit finished job count

endpackage
